// ==== design/device_access.sv ====
`timescale 1ns/1ps
`include "soc_core_cfg.svh"

module device_access
  import soc_core_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      s1_valid_i,
  input  logic                      s1_we_i,
  input  dev_sel_t                  s1_dev_i,
  input  logic                      s1_fault_i,
  input  logic [`SOC_INDEX_W-1:0]   s1_index_i,
  input  logic [`SOC_DAT_W-1:0]     s1_dat_i,
  output logic                      rsp_stb_o,    // One cycle per request
  output logic [`SOC_DAT_W-1:0]     rsp_dat_o,
  output logic                      rsp_fault_o,
  output logic [`SOC_PEND_BITS-1:0] pend_o        // From the I/O block
);

  localparam int rom_pad_w = `SOC_DAT_W - `SOC_ROM_TAG_W - `SOC_INDEX_W;

  logic [`SOC_DAT_W-1:0] ram_mem [`SOC_RAM_WORDS];  // Data RAM
  logic [`SOC_DAT_W-1:0] rom_word;
  logic [`SOC_DAT_W-1:0] io_rdata;
  logic [`SOC_DAT_W-1:0] rd_data;
  logic                  commit;
  logic                  ram_we;
  logic                  io_stb;
  logic                  fault_pulse;
  io_reg_t               io_reg;

  assign commit      = s1_valid_i && !s1_fault_i;    // Request allowed to act
  assign ram_we      = commit && s1_we_i && (s1_dev_i == DEV_RAM);
  assign io_stb      = commit && (s1_dev_i == DEV_IO);
  assign io_reg      = io_reg_t'(s1_index_i[1:0]);  // Low word bits pick reg
  assign fault_pulse = s1_valid_i && s1_fault_i;     // Latched as pending bit 6

  // Boot ROM image, tag in the upper half
  assign rom_word = {`SOC_ROM_TAG, {rom_pad_w{1'b0}}, s1_index_i};

  // Read mux, writes and faults return zero
  always_comb
  begin
    rd_data = '0;
    if (!s1_fault_i && !s1_we_i)
    begin
      case (s1_dev_i)
        DEV_ROM: rd_data = rom_word;
        DEV_RAM: rd_data = ram_mem[s1_index_i];
        DEV_IO:  rd_data = io_rdata;
        default: rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ram_we)
      ram_mem[s1_index_i] <= s1_dat_i;     // Visible to the next request
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rsp_stb_o   <= 1'b0;
      rsp_fault_o <= 1'b0;
    end
    else
    begin
      rsp_stb_o   <= s1_valid_i;
      rsp_fault_o <= fault_pulse;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (s1_valid_i)
      rsp_dat_o <= rd_data;                // Held until the next response
  end

  io_regs io0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .io_stb_i   (io_stb),
    .io_we_i    (s1_we_i),
    .io_reg_i   (io_reg),
    .io_dat_i   (s1_dat_i),
    .fault_i    (fault_pulse),
    .io_rdata_o (io_rdata),
    .pend_o     (pend_o)
  );

  // Fault flag only rides on a response
  a_fault_with_stb : assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_fault_o |-> rsp_stb_o);

endmodule

// ==== design/io_regs.sv ====
`timescale 1ns/1ps
`include "soc_core_cfg.svh"

module io_regs
  import soc_core_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      io_stb_i,    // Committed I/O access
  input  logic                      io_we_i,
  input  io_reg_t                   io_reg_i,
  input  logic [`SOC_DAT_W-1:0]     io_dat_i,
  input  logic                      fault_i,     // Faulted request commits
  output logic [`SOC_DAT_W-1:0]     io_rdata_o,  // Combinational read data
  output logic [`SOC_PEND_BITS-1:0] pend_o
);

  localparam int mmu_bit    = `SOC_PEND_BITS - 1;  // Fault source
  localparam int timer0_bit = 2;

  logic [`SOC_PEND_BITS-1:0] pend_q;
  logic [`SOC_PEND_BITS-1:0] pend_set;
  logic [`SOC_PEND_BITS-1:0] pend_clr;
  logic [`SOC_DAT_W-1:0]     timer_cnt;
  logic                      timer_run;    // Reload active
  logic                      timer_fire;
  logic                      io_wr;

  assign io_wr      = io_stb_i && io_we_i;
  assign timer_fire = timer_run && (timer_cnt == 1);  // Last count
  assign pend_o     = pend_q;

  // Set and clear masks for this cycle
  always_comb
  begin
    pend_set = '0;
    pend_clr = '0;
    if (io_wr && (io_reg_i == IO_PEND_SET))
      pend_set[mmu_bit-1:0] = io_dat_i[mmu_bit-1:0];  // Software cannot fake a fault
    if (io_wr && (io_reg_i == IO_PEND_CLR))
      pend_clr = io_dat_i[`SOC_PEND_BITS-1:0];
    pend_set[timer0_bit] = pend_set[timer0_bit] | timer_fire;
    pend_set[mmu_bit]    = fault_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pend_q <= '0;
    else
      pend_q <= (pend_q & ~pend_clr) | pend_set;  // Set beats clear
  end

  // Down counter, one shot
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      timer_cnt <= '0;
      timer_run <= 1'b0;
    end
    else if (io_wr && (io_reg_i == IO_TIMER0))
    begin
      timer_cnt <= io_dat_i;               // Zero load stops it
      timer_run <= (io_dat_i != '0);
    end
    else if (timer_run)
    begin
      timer_cnt <= timer_cnt - 1'b1;
      if (timer_fire)
        timer_run <= 1'b0;                 // Stop at zero
    end
  end

  // Read side
  always_comb
  begin
    case (io_reg_i)
      IO_PEND:   io_rdata_o = `SOC_DAT_W'(pend_q);
      IO_TIMER0: io_rdata_o = timer_cnt;   // Live count
      default:   io_rdata_o = '0;          // Set and clear are write only
    endcase
  end

  // Idle timer holds zero
  a_timer_idle : assert property (@(posedge clk_i) disable iff (rst_i)
    !timer_run |-> timer_cnt == '0);

endmodule

// ==== design/irq_prio.sv ====
`timescale 1ns/1ps
`include "soc_core_cfg.svh"

module irq_prio
  import soc_core_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      int_en_i,  // CPU interrupt enable
  input  logic [`SOC_PEND_BITS-1:0] pend_i,
  output exc_code_t                 cpu_interrupt_o
);

  exc_code_t code_nxt;

  // Highest bit wins, MMU fault first
  always_comb
  begin
    code_nxt = EXC_RESET;
    if (int_en_i)
    begin
      casez (pend_i)
        7'b1??????: code_nxt = EXC_MMU;
        7'b01?????: code_nxt = EXC_TIMER3;
        7'b001????: code_nxt = EXC_TIMER2;
        7'b0001???: code_nxt = EXC_TIMER1;
        7'b00001??: code_nxt = EXC_TIMER0;
        7'b000001?: code_nxt = EXC_UART0_RX;
        7'b0000001: code_nxt = EXC_UART0_TX;
        default:    code_nxt = EXC_RESET;   // Nothing pending
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      cpu_interrupt_o <= EXC_RESET;
    else
      cpu_interrupt_o <= code_nxt;          // One edge behind pend_i
  end

endmodule

// ==== design/mmu_decode.sv ====
`timescale 1ns/1ps
`include "soc_core_cfg.svh"

module mmu_decode
  import soc_core_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_stb_i,     // One-cycle request strobe
  input  logic                    req_we_i,
  input  logic [`SOC_ADR_W-1:0]   req_adr_i,     // Byte address
  input  logic [`SOC_DAT_W-1:0]   req_dat_i,
  input  logic                    supervisor_i,  // CPU mode level
  output logic                    s1_valid_o,
  output logic                    s1_we_o,
  output dev_sel_t                s1_dev_o,
  output logic                    s1_fault_o,
  output logic [`SOC_INDEX_W-1:0] s1_index_o,    // Word index within device
  output logic [`SOC_DAT_W-1:0]   s1_dat_o
);

  localparam int region_lsb = `SOC_ADR_W - `SOC_REGION_BITS;
  localparam int ofs_w      = region_lsb - 2;    // Word offset inside a region

  localparam logic [`SOC_ADR_W-1:0] rom_base = `SOC_ROM_BASE;
  localparam logic [`SOC_ADR_W-1:0] ram_base = `SOC_RAM_BASE;
  localparam logic [`SOC_ADR_W-1:0] io_base  = `SOC_IO_BASE;
  localparam logic [ofs_w-1:0]      rom_words = `SOC_ROM_WORDS;
  localparam logic [ofs_w-1:0]      ram_words = `SOC_RAM_WORDS;

  logic [`SOC_REGION_BITS-1:0] region;
  logic [ofs_w-1:0]            word_ofs;
  dev_sel_t                    dev;
  logic                        fault;

  assign region   = req_adr_i[`SOC_ADR_W-1:region_lsb];  // Top bits pick region
  assign word_ofs = req_adr_i[region_lsb-1:2];           // Byte lanes ignored

  // Region to device
  always_comb
  begin
    dev = DEV_NONE;
    if (region == rom_base[`SOC_ADR_W-1:region_lsb])
      dev = DEV_ROM;
    else if (region == ram_base[`SOC_ADR_W-1:region_lsb])
      dev = DEV_RAM;
    else if (region == io_base[`SOC_ADR_W-1:region_lsb])
      dev = DEV_IO;
  end

  // Access rights and depth limits
  always_comb
  begin
    case (dev)
      DEV_ROM: fault = req_we_i || (word_ofs >= rom_words);  // Write protect
      DEV_RAM: fault = word_ofs >= ram_words;
      DEV_IO:  fault = !supervisor_i;                        // Supervisor only
      default: fault = 1'b1;                                 // Unmapped
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      s1_valid_o <= 1'b0;
    else
      s1_valid_o <= req_stb_i;                // Strobe moves one stage
  end

  // Payload only loads with a request
  always_ff @(posedge clk_i)
  begin
    if (req_stb_i)
    begin
      s1_we_o    <= req_we_i;
      s1_dev_o   <= dev;
      s1_fault_o <= fault;
      s1_index_o <= word_ofs[`SOC_INDEX_W-1:0];
      s1_dat_o   <= req_dat_i;
    end
  end

  // A good request always targets a real device
  a_dev_mapped : assert property (@(posedge clk_i) disable iff (rst_i)
    s1_valid_o && !s1_fault_o |-> s1_dev_o != DEV_NONE);

endmodule

// ==== design/soc_core.sv ====
`timescale 1ns/1ps
`include "soc_core_cfg.svh"

module soc_core
  import soc_core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_stb_i,
  input  logic                  req_we_i,
  input  logic [`SOC_ADR_W-1:0] req_adr_i,
  input  logic [`SOC_DAT_W-1:0] req_dat_i,
  input  logic                  supervisor_i,
  input  logic                  int_en_i,
  output logic                  rsp_stb_o,
  output logic [`SOC_DAT_W-1:0] rsp_dat_o,
  output logic                  rsp_fault_o,
  output exc_code_t             cpu_interrupt_o
);

  // Stage 1 to stage 2
  logic                      s1_valid;
  logic                      s1_we;
  dev_sel_t                  s1_dev;
  logic                      s1_fault;
  logic [`SOC_INDEX_W-1:0]   s1_index;
  logic [`SOC_DAT_W-1:0]     s1_dat;
  logic [`SOC_PEND_BITS-1:0] pend;          // Interrupt sources

  mmu_decode mmu0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_stb_i    (req_stb_i),
    .req_we_i     (req_we_i),
    .req_adr_i    (req_adr_i),
    .req_dat_i    (req_dat_i),
    .supervisor_i (supervisor_i),
    .s1_valid_o   (s1_valid),
    .s1_we_o      (s1_we),
    .s1_dev_o     (s1_dev),
    .s1_fault_o   (s1_fault),
    .s1_index_o   (s1_index),
    .s1_dat_o     (s1_dat)
  );

  device_access dev0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s1_valid_i  (s1_valid),
    .s1_we_i     (s1_we),
    .s1_dev_i    (s1_dev),
    .s1_fault_i  (s1_fault),
    .s1_index_i  (s1_index),
    .s1_dat_i    (s1_dat),
    .rsp_stb_o   (rsp_stb_o),
    .rsp_dat_o   (rsp_dat_o),
    .rsp_fault_o (rsp_fault_o),
    .pend_o      (pend)
  );

  irq_prio irq0 (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .int_en_i        (int_en_i),
    .pend_i          (pend),
    .cpu_interrupt_o (cpu_interrupt_o)
  );

endmodule

// ==== design/soc_core_cfg.svh ====
`ifndef SOC_CORE_CFG_SVH
`define SOC_CORE_CFG_SVH

// Bus widths
`define SOC_ADR_W        32
`define SOC_DAT_W        32

// Region select uses the top address bits
`define SOC_REGION_BITS  4

// Address map
`define SOC_ROM_BASE     32'h0000_0000
`define SOC_RAM_BASE     32'h1000_0000
`define SOC_IO_BASE      32'h2000_0000

// Memory depths in words
`define SOC_ROM_WORDS    256
`define SOC_RAM_WORDS    1024
`define SOC_INDEX_W      10

// ROM contents are tag plus word index
`define SOC_ROM_TAG      16'hB105
`define SOC_ROM_TAG_W    16

// Interrupt sources, MMU fault is the top bit
`define SOC_PEND_BITS    7

`endif

// ==== design/soc_core_pkg.sv ====
package soc_core_pkg;

  // Target of a decoded request
  typedef enum logic [1:0] {
    DEV_NONE = 2'd0,                     // Unmapped region
    DEV_ROM  = 2'd1,                     // Boot ROM, read only
    DEV_RAM  = 2'd2,                     // Data RAM
    DEV_IO   = 2'd3                      // I/O register block
  } dev_sel_t;

  // I/O register index, from the low word-address bits
  typedef enum logic [1:0] {
    IO_PEND     = 2'd0,                  // Pending bits, read
    IO_PEND_SET = 2'd1,                  // Ones set bits 5..0
    IO_PEND_CLR = 2'd2,                  // Ones clear bits 6..0
    IO_TIMER0   = 2'd3                   // Write reload, read count
  } io_reg_t;

  // Exception code seen by the CPU
  typedef enum logic [3:0] {
    EXC_RESET    = 4'd0,                 // Nothing pending
    EXC_MMU      = 4'd1,                 // Access fault, top priority
    EXC_TIMER3   = 4'd2,
    EXC_TIMER2   = 4'd3,
    EXC_TIMER1   = 4'd4,
    EXC_TIMER0   = 4'd5,
    EXC_UART0_RX = 4'd6,
    EXC_UART0_TX = 4'd7                  // Lowest priority
  } exc_code_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the soc_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f soc_core.f --top-module soc_core_tb \
  || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/Vsoc_core_tb)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== soc_core.f ====
+incdir+design
+incdir+verification
design/soc_core_pkg.sv
design/mmu_decode.sv
design/io_regs.sv
design/device_access.sv
design/irq_prio.sv
design/soc_core.sv
verification/soc_core_tb.sv

// ==== verification/soc_core_model.svh ====
`ifndef SOC_CORE_MODEL_SVH
`define SOC_CORE_MODEL_SVH

localparam int region_sh = 32 - `SOC_REGION_BITS;  // Region field position

logic [31:0] ram_img   [`SOC_RAM_WORDS];   // RAM mirror
bit          ram_known [`SOC_RAM_WORDS];   // Index written at least once
logic [6:0]  pend_img;                     // Expected pending bits

// Responses still due, in issue order
logic [31:0] exp_dat_q   [$];
logic        exp_fault_q [$];

// Boot ROM word is tag over word index
function automatic logic [31:0] rom_word(input logic [25:0] idx);
  return {`SOC_ROM_TAG, idx[15:0]};
endfunction

// Highest set bit wins, bit 6 maps to code 1, bit 0 to code 7
function automatic exc_code_t prio_code(input logic [6:0] bits, input logic en);
  exc_code_t code;
  code = EXC_RESET;
  for (int i = 0; i < 7; i++)
  begin
    if (en && bits[i])
      code = exc_code_t'(4'(7 - i));       // Higher bits overwrite
  end
  return code;
endfunction

// Expected response and side effects of one request
task automatic predict(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                       input logic sup);
  logic [31:0] region;
  logic [25:0] ofs;
  logic [31:0] rdat;
  logic        fault;
  region = adr >> region_sh;
  ofs    = adr[27:2];                      // Byte lanes dropped
  rdat   = '0;
  fault  = 1'b1;                           // Unmapped unless matched
  if (region == (`SOC_ROM_BASE >> region_sh))
  begin
    fault = we || (ofs >= 26'(`SOC_ROM_WORDS));
    rdat  = rom_word(ofs);
  end
  else if (region == (`SOC_RAM_BASE >> region_sh))
  begin
    fault = ofs >= 26'(`SOC_RAM_WORDS);
    if (!fault && we)
    begin
      ram_img[ofs[9:0]]   = dat;
      ram_known[ofs[9:0]] = 1'b1;
    end
    rdat = ram_img[ofs[9:0]];
  end
  else if (region == (`SOC_IO_BASE >> region_sh))
  begin
    fault = !sup;                          // Supervisor only
    rdat  = '0;                            // Timer read only once expired
    if (!fault && we && io_reg_t'(ofs[1:0]) == IO_PEND_SET)
      pend_img[5:0] = pend_img[5:0] | dat[5:0];
    if (!fault && we && io_reg_t'(ofs[1:0]) == IO_PEND_CLR)
      pend_img = pend_img & ~dat[6:0];
    if (io_reg_t'(ofs[1:0]) == IO_PEND)
      rdat = {25'b0, pend_img};
  end
  if (fault)
    pend_img[6] = 1'b1;                    // Fault source latched
  exp_dat_q.push_back((fault || we) ? 32'h0 : rdat);
  exp_fault_q.push_back(fault);
endtask

`endif

// ==== verification/soc_core_tb.sv ====
`timescale 1ns/1ps
`include "soc_core_cfg.svh"

module soc_core_tb
  import soc_core_pkg::*;
();

  localparam int n_ram       = 200;
  localparam int n_rom       = 40;
  localparam int n_prio      = 30;
  localparam int n_timer     = 4;
  localparam int max_reload  = 32;
  localparam int cycle_limit = 100 + n_ram + n_rom + n_prio * 12
                               + n_timer * (max_reload + 30) + 200;  // Margin

  logic        clk;
  logic        rst;
  logic        req_stb;
  logic        req_we;
  logic [31:0] req_adr;
  logic [31:0] req_dat;
  logic        supervisor;
  logic        int_en;
  logic        rsp_stb;
  logic [31:0] rsp_dat;
  logic        rsp_fault;
  exc_code_t   cpu_interrupt;
  integer      seed;
  int          errors = 0;
  int          checks = 0;
  int          errors_before = 0;        // Count at start of current test
  int          cycles = 0;

  `include "soc_core_model.svh"

  soc_core i_soc_core (
    .clk_i           (clk),
    .rst_i           (rst),
    .req_stb_i       (req_stb),
    .req_we_i        (req_we),
    .req_adr_i       (req_adr),
    .req_dat_i       (req_dat),
    .supervisor_i    (supervisor),
    .int_en_i        (int_en),
    .rsp_stb_o       (rsp_stb),
    .rsp_dat_o       (rsp_dat),
    .rsp_fault_o     (rsp_fault),
    .cpu_interrupt_o (cpu_interrupt)
  );

  always #4 clk = ~clk;                  // 8 ns period

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Run stopped after %0d cycles with responses still missing", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERROR at %0d ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // Every response against the head of the queue
  always @(negedge clk)
  begin
    if (!rst && rsp_stb)
    begin
      if (exp_dat_q.size() == 0)
      begin
        errors++;
        $display("Response at %0d ns with no request outstanding", $time);
      end
      else
      begin
        compare("rsp_dat_o", exp_dat_q.pop_front(), rsp_dat);
        compare("rsp_fault_o", 32'(exp_fault_q.pop_front()), 32'(rsp_fault));
      end
    end
  end

  function automatic logic [31:0] io_adr(input io_reg_t r);
    return `SOC_IO_BASE + (32'(r) << 2);
  endfunction

  // Called 1 ns after an edge, returns 1 ns after the next
  task automatic send(input logic we, input logic [31:0] adr, input logic [31:0] dat);
    req_stb = 1'b1;
    req_we  = we;
    req_adr = adr;
    req_dat = dat;
    predict(we, adr, dat, supervisor);
    @(posedge clk);
    #1;
    req_stb = 1'b0;
  endtask

  task automatic drain();
    while (exp_dat_q.size() != 0)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // Interrupt code one cycle after the last response
  task automatic check_irq(input exc_code_t exp);
    drain();
    @(posedge clk);
    #1;
    compare("cpu_interrupt_o", 32'(exp), 32'(cpu_interrupt));
  endtask

  task automatic report(input string name);
    drain();
    $display("Test %s finished, %0d mismatches", name, errors - errors_before);
    errors_before = errors;
  endtask

  initial
  begin
    logic [31:0] r;
    logic [9:0]  idx;
    int          reload;
    seed       = 40;
    clk        = 1'b0;
    rst        = 1'b1;
    req_stb    = 1'b0;
    req_we     = 1'b0;
    req_adr    = '0;
    req_dat    = '0;
    supervisor = 1'b1;
    int_en     = 1'b0;
    pend_img   = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    compare("rsp_stb_o", 32'h0, 32'(rsp_stb));
    compare("rsp_fault_o", 32'h0, 32'(rsp_fault));
    compare("cpu_interrupt_o", 32'(EXC_RESET), 32'(cpu_interrupt));
    report("reset");

    for (int n = 0; n < n_ram; n++)
    begin
      r   = $random(seed);
      idx = 10'(r[8:4]);                 // 32 words keep reads likely
      send(!(r[31] && ram_known[idx]), `SOC_RAM_BASE + {20'b0, idx, r[1:0]}, $random(seed));
    end
    report("ram");

    for (int n = 0; n < n_rom; n++)
    begin
      r = $random(seed);
      send(1'b0, `SOC_ROM_BASE + {22'b0, r[7:0], 2'b00}, 32'h0);
    end
    r = $random(seed);
    send(1'b1, `SOC_ROM_BASE + {22'b0, r[7:0], 2'b00}, $random(seed));  // Write protected
    send(1'b0, `SOC_ROM_BASE + {22'b0, r[7:0], 2'b00}, 32'h0);
    send(1'b0, `SOC_ROM_BASE + 32'h400, 32'h0);                         // Past ROM depth
    send(1'b1, io_adr(IO_PEND_CLR), 32'h40);
    report("rom");

    int_en = 1'b1;
    r = $random(seed);
    send(1'b0, {4'h3 + 4'(r[31:28] % 13), r[27:0]}, 32'h0);  // Unmapped region
    check_irq(EXC_MMU);
    send(1'b1, io_adr(IO_PEND_CLR), 32'h40);
    check_irq(EXC_RESET);
    supervisor = 1'b0;
    send(r[0], io_adr(io_reg_t'(r[3:2])), $random(seed));   // User mode I/O
    supervisor = 1'b1;
    check_irq(EXC_MMU);
    send(1'b1, io_adr(IO_PEND_CLR), 32'h40);
    check_irq(EXC_RESET);
    report("access");

    for (int n = 0; n < n_prio; n++)
    begin
      r = $random(seed);
      int_en = r[31];
      send(1'b1, io_adr(IO_PEND_SET), $random(seed));
      send(1'b1, io_adr(IO_PEND_CLR), $random(seed));
      send(1'b0, io_adr(IO_PEND), 32'h0);
      check_irq(prio_code(pend_img, int_en));
    end
    send(1'b1, io_adr(IO_PEND_CLR), 32'h7F);
    report("priority");

    int_en = 1'b1;
    for (int n = 0; n < n_timer; n++)
    begin
      r = $random(seed);
      reload = int'(r[4:0]) + 1;         // 1 to max_reload
      send(1'b1, io_adr(IO_TIMER0), 32'(reload));
      drain();
      repeat (reload + 2) @(posedge clk);
      #1;
      pend_img[2] = 1'b1;                // Expired by now
      send(1'b0, io_adr(IO_PEND), 32'h0);
      send(1'b0, io_adr(IO_TIMER0), 32'h0);
      check_irq(EXC_TIMER0);
      send(1'b1, io_adr(IO_PEND_CLR), 32'h4);
      check_irq(EXC_RESET);
    end
    report("timer");

    $display("Totals: %0d checks, %0d mismatches", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule
